// File: rtl/regmap_params.svh
`ifndef REGMAP_PARAMS_SVH
`define REGMAP_PARAMS_SVH

// word and bus widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 16
`define SLOT_COUNT 16

// slot 0 sits on a 64-byte boundary and slots are 4 bytes apart
`define BASE_ADDR 16'h0100

// slot ids
`define BURST_SIZE_ID 4
`define SCALE_ID 5
`define POLL_FIRST_ID 6
`define POLL_LAST_ID 7
`define VERSION_ID 8
`define SLOT_COUNT_ID 9
`define MAX_BURST_ID 10

// every slot from here up is unmapped
`define MAPPED_CEILING_ID 11

// limits and constants
`define MAX_BURST_SIZE 32'd64
`define MAX_SCALE 32'd1000
`define FIRMWARE_VERSION 32'h0001_0003

// write response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

// File: rtl/regmap_pkg.sv
`include "regmap_params.svh"

package regmap_pkg;

	localparam int OFFSET_WIDTH = 2;
	localparam int SLOT_ID_WIDTH = $clog2(`SLOT_COUNT);
	localparam int UPPER_WIDTH = `ADDR_WIDTH - SLOT_ID_WIDTH - OFFSET_WIDTH;
	localparam logic [`ADDR_WIDTH-1:0] LAST_SLOT_ADDR = `BASE_ADDR + 4 * (`SLOT_COUNT - 1);

	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [SLOT_ID_WIDTH-1:0] slot_id_t;
	typedef logic [`SLOT_COUNT-1:0] slot_vec_t;
	typedef data_t [`SLOT_COUNT-1:0] slot_data_t;

	typedef struct packed {
		logic [UPPER_WIDTH-1:0] upper;
		slot_id_t slot;
		logic [OFFSET_WIDTH-1:0] offset;
	} addr_fields_t;

	// one bus address, seen either as a byte address or split into its fields
	typedef union packed {
		logic [`ADDR_WIDTH-1:0] raw;
		addr_fields_t fields;
	} addr_word_u;

	typedef struct packed {
		logic in_range;
		slot_id_t id;
	} slot_decode_t;

	function automatic slot_decode_t decode_addr(addr_word_u addr);
		slot_decode_t dec;
		dec.in_range = (addr.fields.offset == '0)
			&& (addr.raw >= `BASE_ADDR)
			&& (addr.raw <= LAST_SLOT_ADDR);
		// the base is 64-byte aligned so the slot field is the slot index
		dec.id = addr.fields.slot;
		return dec;
	endfunction

endpackage

// File: rtl/reg_write_if.sv
`timescale 1ns/1ps

// bus write commits from the write port into the register bank
interface reg_write_if;

	logic commit_req;
	regmap_pkg::slot_id_t commit_id;
	regmap_pkg::data_t commit_data;
	// high in the cycle the bank stores the word
	logic commit_done;

	modport writer (
		output commit_req,
		output commit_id,
		output commit_data,
		input  commit_done
	);

	modport bank (
		input  commit_req,
		input  commit_id,
		input  commit_data,
		output commit_done
	);

endinterface

// File: rtl/reg_read_if.sv
`timescale 1ns/1ps

// slot lookups from the read port, answered combinationally by the bank
interface reg_read_if;

	regmap_pkg::slot_id_t lookup_id;
	regmap_pkg::data_t lookup_data;

	modport reader (
		output lookup_id,
		input  lookup_data
	);

	modport bank (
		input  lookup_id,
		output lookup_data
	);

endinterface

// File: rtl/axi_write_port.sv
`timescale 1ns/1ps
`include "regmap_params.svh"

module axi_write_port (
	input  logic clk,
	input  logic arst_n,
	input  logic aw_valid,
	output logic aw_ready,
	input  regmap_pkg::addr_word_u aw_addr,
	input  logic w_valid,
	output logic w_ready,
	input  regmap_pkg::data_t w_data,
	output logic b_valid,
	input  logic b_ready,
	output logic [1:0] b_resp,
	reg_write_if.writer commit
);

	logic aw_held;
	logic w_held;
	logic aw_fire;
	logic w_fire;
	logic both_captured;
	regmap_pkg::slot_decode_t dec_in;
	regmap_pkg::slot_decode_t dec_now;
	regmap_pkg::slot_decode_t dec_q;
	regmap_pkg::data_t data_q;

	// a channel stays closed while it holds its item
	assign aw_ready = ~aw_held;
	assign w_ready = ~w_held;
	assign aw_fire = aw_valid & aw_ready;
	assign w_fire = w_valid & w_ready;

	assign dec_in = regmap_pkg::decode_addr(aw_addr);
	assign dec_now = aw_fire ? dec_in : dec_q;

	// true at the edge where the later of address and data arrives
	assign both_captured = (aw_fire | w_fire) & (aw_held | aw_fire) & (w_held | w_fire);

	assign commit.commit_id = dec_q.id;
	assign commit.commit_data = data_q;

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			dec_q <= dec_in;
		end
		if (w_fire) begin
			data_q <= w_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			commit.commit_req <= 1'b0;
			b_valid <= 1'b0;
			b_resp <= `RESP_OKAY;
		end else begin
			if (aw_fire) begin
				aw_held <= 1'b1;
			end
			if (w_fire) begin
				w_held <= 1'b1;
			end
			if (both_captured) begin
				if (dec_now.in_range) begin
					commit.commit_req <= 1'b1;
				end else begin
					b_valid <= 1'b1;
					b_resp <= `RESP_SLVERR;
				end
			end
			if (commit.commit_done) begin
				commit.commit_req <= 1'b0;
				b_valid <= 1'b1;
				b_resp <= `RESP_OKAY;
			end
			// response accepted so both channels open again
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				aw_held <= 1'b0;
				w_held <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/axi_read_port.sv
`timescale 1ns/1ps

module axi_read_port (
	input  logic clk,
	input  logic arst_n,
	input  logic ar_valid,
	output logic ar_ready,
	input  regmap_pkg::addr_word_u ar_addr,
	output logic r_valid,
	input  logic r_ready,
	output regmap_pkg::data_t r_data,
	reg_read_if.reader lookup
);

	// all ones minus one marks an address outside the register window
	localparam regmap_pkg::data_t OUT_OF_RANGE_WORD = ~regmap_pkg::data_t'(1);

	logic ar_fire;
	regmap_pkg::slot_decode_t dec;

	// one read in flight, so no new address while data waits
	assign ar_ready = ~r_valid;
	assign ar_fire = ar_valid & ar_ready;

	assign dec = regmap_pkg::decode_addr(ar_addr);
	assign lookup.lookup_id = dec.id;

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			if (dec.in_range) begin
				r_data <= lookup.lookup_data;
			end else begin
				r_data <= OUT_OF_RANGE_WORD;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r_valid <= 1'b0;
		end else begin
			if (ar_fire) begin
				r_valid <= 1'b1;
			end else if (r_ready) begin
				r_valid <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`include "regmap_params.svh"

module reg_bank (
	input  logic clk,
	input  logic arst_n,
	input  regmap_pkg::slot_vec_t fab_wr_req,
	input  regmap_pkg::slot_data_t fab_wr_data,
	input  regmap_pkg::slot_vec_t fab_rd_req,
	output regmap_pkg::slot_data_t fab_rd_data,
	output regmap_pkg::slot_vec_t fresh,
	reg_write_if.bank commit,
	reg_read_if.bank lookup
);

	// current word of every slot as the bus and the fabric see it
	regmap_pkg::data_t view [`SLOT_COUNT];

	function automatic regmap_pkg::data_t clamp(int id, regmap_pkg::data_t word);
		regmap_pkg::data_t limited;
		limited = word;
		if (id == `BURST_SIZE_ID && word > `MAX_BURST_SIZE) begin
			limited = `MAX_BURST_SIZE;
		end
		if (id == `SCALE_ID && word > `MAX_SCALE) begin
			limited = `MAX_SCALE;
		end
		return limited;
	endfunction

	function automatic regmap_pkg::data_t constant_word(int id);
		regmap_pkg::data_t word;
		case (id)
			`VERSION_ID:    word = `FIRMWARE_VERSION;
			`SLOT_COUNT_ID: word = `SLOT_COUNT;
			`MAX_BURST_ID:  word = `MAX_BURST_SIZE;
			default:        word = '1;
		endcase
		return word;
	endfunction

	// a fabric write to the target slot holds the bus commit off
	assign commit.commit_done = commit.commit_req & ~fab_wr_req[commit.commit_id];

	assign lookup.lookup_data = view[lookup.lookup_id];

	for (genvar g = 0; g < `SLOT_COUNT; g++) begin : slot
		if (g <= `POLL_LAST_ID) begin : stored
			localparam bit FABRIC_WRITABLE = (g < `POLL_FIRST_ID);

			logic bus_store;
			logic fab_store;
			regmap_pkg::data_t word_q;
			logic fresh_q;

			assign bus_store = commit.commit_done
				&& (commit.commit_id == regmap_pkg::slot_id_t'(g));
			// poll slots only take words from the bus
			assign fab_store = fab_wr_req[g] && FABRIC_WRITABLE;

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					word_q <= '0;
					fresh_q <= 1'b0;
				end else begin
					if (fab_store) begin
						word_q <= clamp(g, fab_wr_data[g]);
					end else if (bus_store) begin
						word_q <= clamp(g, commit.commit_data);
					end
					if (bus_store) begin
						fresh_q <= 1'b1;
					end else if (fab_rd_req[g]) begin
						fresh_q <= 1'b0;
					end
				end
			end

			assign view[g] = word_q;
			assign fresh[g] = fresh_q;
		end else if (g < `MAPPED_CEILING_ID) begin : constant
			assign view[g] = constant_word(g);
			assign fresh[g] = 1'b0;
		end else begin : unmapped
			assign view[g] = '1;
			assign fresh[g] = 1'b0;
		end
	end

	// view still holds the word from before this edge, so reads see the old value
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fab_rd_data <= '0;
		end else begin
			for (int i = 0; i < `SLOT_COUNT; i++) begin
				if (fab_rd_req[i]) begin
					fab_rd_data[i] <= view[i];
				end
			end
		end
	end

endmodule

// File: rtl/reg_slave_top.sv
`timescale 1ns/1ps

module reg_slave_top (
	input  logic clk,
	input  logic arst_n,
	input  logic aw_valid,
	output logic aw_ready,
	input  regmap_pkg::addr_word_u aw_addr,
	input  logic w_valid,
	output logic w_ready,
	input  regmap_pkg::data_t w_data,
	output logic b_valid,
	input  logic b_ready,
	output logic [1:0] b_resp,
	input  logic ar_valid,
	output logic ar_ready,
	input  regmap_pkg::addr_word_u ar_addr,
	output logic r_valid,
	input  logic r_ready,
	output regmap_pkg::data_t r_data,
	input  regmap_pkg::slot_vec_t fab_wr_req,
	input  regmap_pkg::slot_data_t fab_wr_data,
	input  regmap_pkg::slot_vec_t fab_rd_req,
	output regmap_pkg::slot_data_t fab_rd_data,
	output regmap_pkg::slot_vec_t fresh
);

	reg_write_if commit_if ();
	reg_read_if lookup_if ();

	axi_write_port axi_write_port_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.aw_addr  (aw_addr),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.w_data   (w_data),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.b_resp   (b_resp),
		.commit   (commit_if.writer)
	);

	axi_read_port axi_read_port_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar_addr  (ar_addr),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.r_data   (r_data),
		.lookup   (lookup_if.reader)
	);

	reg_bank reg_bank_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.fab_wr_req  (fab_wr_req),
		.fab_wr_data (fab_wr_data),
		.fab_rd_req  (fab_rd_req),
		.fab_rd_data (fab_rd_data),
		.fresh       (fresh),
		.commit      (commit_if.bank),
		.lookup      (lookup_if.bank)
	);

endmodule

// File: verification/reg_slave_model.svh
`ifndef REG_SLAVE_MODEL_SVH
`define REG_SLAVE_MODEL_SVH

// expected slot words and fresh flags, kept in step with the drivers
regmap_pkg::data_t model_slot [`SLOT_COUNT];
regmap_pkg::slot_vec_t model_fresh;

function automatic bit addr_in_range(input logic [15:0] addr);
	return addr[1:0] == 2'b00 && addr >= `BASE_ADDR
		&& addr <= 16'(`BASE_ADDR + 4 * (`SLOT_COUNT - 1));
endfunction

function automatic regmap_pkg::slot_id_t addr_slot(input logic [15:0] addr);
	return regmap_pkg::slot_id_t'((addr - `BASE_ADDR) >> 2);
endfunction

function automatic logic [15:0] slot_addr(input regmap_pkg::slot_id_t id);
	return 16'(`BASE_ADDR + 4 * id);
endfunction

function automatic regmap_pkg::data_t limit_word(input regmap_pkg::slot_id_t id,
		input regmap_pkg::data_t word);
	return (id == `BURST_SIZE_ID && word > `MAX_BURST_SIZE) ? `MAX_BURST_SIZE
		: (id == `SCALE_ID && word > `MAX_SCALE) ? `MAX_SCALE : word;
endfunction

function automatic regmap_pkg::data_t model_view(input regmap_pkg::slot_id_t id);
	if (id <= `POLL_LAST_ID) begin
		return model_slot[id];
	end
	case (id)
		`VERSION_ID:    return `FIRMWARE_VERSION;
		`SLOT_COUNT_ID: return 32'(`SLOT_COUNT);
		`MAX_BURST_ID:  return `MAX_BURST_SIZE;
		default:        return '1;
	endcase
endfunction

function automatic regmap_pkg::data_t expected_read(input logic [15:0] addr);
	return addr_in_range(addr) ? model_view(addr_slot(addr)) : 32'hFFFF_FFFE;
endfunction

task automatic compare_word(input string name, input regmap_pkg::data_t got,
		input regmap_pkg::data_t expected);
	if (got !== expected) begin
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		error_count++;
	end
endtask

task automatic model_bus_commit(input logic [15:0] addr, input regmap_pkg::data_t data);
	regmap_pkg::slot_id_t id;
	id = addr_slot(addr);
	if (addr_in_range(addr) && id <= `POLL_LAST_ID) begin
		model_slot[id] = limit_word(id, data);
		model_fresh[id] = 1'b1;
	end
endtask

task automatic model_fabric_write(input regmap_pkg::slot_id_t id, input regmap_pkg::data_t data);
	// poll, constant and unmapped slots ignore the fabric
	if (id < `POLL_FIRST_ID) begin
		model_slot[id] = limit_word(id, data);
	end
endtask

task automatic send_addr(input logic [15:0] addr, input int gap);
	repeat (gap) @(posedge clk);
	@(posedge clk);
	aw_valid <= 1'b1;
	aw_addr.raw <= addr;
	@(negedge clk);
	while (!aw_ready) @(negedge clk);
	@(posedge clk);
	aw_valid <= 1'b0;
endtask

task automatic send_data(input regmap_pkg::data_t data, input int gap);
	repeat (gap) @(posedge clk);
	@(posedge clk);
	w_valid <= 1'b1;
	w_data <= data;
	@(negedge clk);
	while (!w_ready) @(negedge clk);
	@(posedge clk);
	w_valid <= 1'b0;
endtask

task automatic collect_response(output logic [1:0] resp, input int stall);
	@(negedge clk);
	while (!b_valid) @(negedge clk);
	resp = b_resp;
	repeat (stall) begin
		@(negedge clk);
		if (!b_valid || b_resp !== resp) begin
			$display("at %0t ns the write response changed while b_ready was low", $time);
			error_count++;
		end
	end
	@(posedge clk);
	b_ready <= 1'b1;
	@(posedge clk);
	b_ready <= 1'b0;
endtask

task automatic bus_write(input logic [15:0] addr, input regmap_pkg::data_t data,
		output logic [1:0] resp);
	int addr_gap;
	int data_gap;
	int stall;
	addr_gap = int'(next_random(2));
	data_gap = int'(next_random(2));
	stall = int'(next_random(3));
	fork
		send_addr(addr, addr_gap);
		send_data(data, data_gap);
	join
	collect_response(resp, stall);
endtask

task automatic read_check(input logic [15:0] addr);
	int gap;
	int stall;
	regmap_pkg::data_t data;
	gap = int'(next_random(2));
	stall = int'(next_random(3));
	repeat (gap) @(posedge clk);
	@(posedge clk);
	ar_valid <= 1'b1;
	ar_addr.raw <= addr;
	@(negedge clk);
	while (!ar_ready) @(negedge clk);
	@(posedge clk);
	ar_valid <= 1'b0;
	// read data follows the address transfer by exactly one cycle
	@(negedge clk);
	compare_word("r_valid", 32'(r_valid), 32'd1);
	data = r_data;
	repeat (stall) begin
		@(negedge clk);
		if (!r_valid || r_data !== data) begin
			$display("at %0t ns the read data changed while r_ready was low", $time);
			error_count++;
		end
	end
	@(posedge clk);
	r_ready <= 1'b1;
	@(posedge clk);
	r_ready <= 1'b0;
	compare_word("r_data", data, expected_read(addr));
endtask

task automatic write_check(input logic [15:0] addr, input regmap_pkg::data_t data);
	logic [1:0] resp;
	bus_write(addr, data, resp);
	compare_word("b_resp", 32'(resp),
		addr_in_range(addr) ? 32'(`RESP_OKAY) : 32'(`RESP_SLVERR));
	model_bus_commit(addr, data);
endtask

task automatic access_check(input logic [15:0] addr, input regmap_pkg::data_t data);
	write_check(addr, data);
	read_check(addr);
endtask

task automatic fabric_write(input regmap_pkg::slot_id_t id, input regmap_pkg::data_t data);
	@(posedge clk);
	fab_wr_req[id] <= 1'b1;
	fab_wr_data[id] <= data;
	@(posedge clk);
	fab_wr_req[id] <= 1'b0;
	model_fabric_write(id, data);
endtask

task automatic fabric_read(input regmap_pkg::slot_id_t id);
	@(posedge clk);
	fab_rd_req[id] <= 1'b1;
	@(posedge clk);
	fab_rd_req[id] <= 1'b0;
	@(negedge clk);
	compare_word("fab_rd_data", fab_rd_data[id], model_view(id));
	model_fresh[id] = 1'b0;
	compare_word("fresh", 32'(fresh), 32'(model_fresh));
endtask

// a write and a read of the same slot at one edge, where the read still sees the old word
task automatic fabric_write_read(input regmap_pkg::slot_id_t id, input regmap_pkg::data_t data);
	regmap_pkg::data_t old_word;
	old_word = model_view(id);
	@(posedge clk);
	fab_wr_req[id] <= 1'b1;
	fab_wr_data[id] <= data;
	fab_rd_req[id] <= 1'b1;
	@(posedge clk);
	fab_wr_req[id] <= 1'b0;
	fab_rd_req[id] <= 1'b0;
	@(negedge clk);
	model_fabric_write(id, data);
	model_fresh[id] = 1'b0;
	compare_word("fab_rd_data", fab_rd_data[id], old_word);
endtask

`endif

// File: verification/reg_slave_tb.sv
`timescale 1ns/1ps
`include "regmap_params.svh"

module reg_slave_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	// bound on the cycles one test can take with all gaps and stalls at their maximum
	localparam int TEST_CYCLE_BUDGET = 1500;
	localparam logic [31:0] LFSR_SEED = 32'd36;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk;
	logic arst_n;
	logic aw_valid;
	logic aw_ready;
	regmap_pkg::addr_word_u aw_addr;
	logic w_valid;
	logic w_ready;
	regmap_pkg::data_t w_data;
	logic b_valid;
	logic b_ready;
	logic [1:0] b_resp;
	logic ar_valid;
	logic ar_ready;
	regmap_pkg::addr_word_u ar_addr;
	logic r_valid;
	logic r_ready;
	regmap_pkg::data_t r_data;
	regmap_pkg::slot_vec_t fab_wr_req;
	regmap_pkg::slot_data_t fab_wr_data;
	regmap_pkg::slot_vec_t fab_rd_req;
	regmap_pkg::slot_data_t fab_rd_data;
	regmap_pkg::slot_vec_t fresh;

	logic [31:0] lfsr_state;
	int error_count;
	int failed_tests;

	// one Galois step for every bit taken, with each new bit entering at the bottom
	function automatic logic [31:0] next_random(input int bits);
		logic [31:0] value;
		logic out_bit;
		value = '0;
		for (int i = 0; i < bits; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit) begin
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			end
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	`include "reg_slave_model.svh"

	reg_slave_top reg_slave_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((RESET_CYCLES + NUM_TESTS * TEST_CYCLE_BUDGET) * CLK_PERIOD);
		$display("watchdog expired at %0t ns before the tests finished", $time);
		$display("Something failed");
		$finish;
	end

	task automatic test_random_access();
		regmap_pkg::slot_id_t id;
		@(negedge clk);
		// every channel is open and nothing is pending right after reset
		compare_word("aw_ready", 32'(aw_ready), 32'd1);
		compare_word("w_ready", 32'(w_ready), 32'd1);
		compare_word("ar_ready", 32'(ar_ready), 32'd1);
		compare_word("b_valid", 32'(b_valid), 32'd0);
		compare_word("r_valid", 32'(r_valid), 32'd0);
		compare_word("fresh", 32'(fresh), 32'd0);
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			compare_word($sformatf("fab_rd_data[%0d]", i), fab_rd_data[i], 32'd0);
		end
		for (int i = 0; i < 4; i++) begin
			read_check(slot_addr(regmap_pkg::slot_id_t'(i)));
		end
		for (int i = 0; i < 8; i++) begin
			id = regmap_pkg::slot_id_t'(next_random(2));
			access_check(slot_addr(id), next_random(32));
		end
	endtask

	task automatic test_clamping();
		access_check(slot_addr(`BURST_SIZE_ID), 32'd65 + next_random(16));
		access_check(slot_addr(`BURST_SIZE_ID), next_random(6));
		access_check(slot_addr(`SCALE_ID), 32'd1001 + next_random(20));
		access_check(slot_addr(`SCALE_ID), next_random(9));
	endtask

	task automatic test_fixed_slots();
		for (int i = `VERSION_ID; i < `SLOT_COUNT; i++) begin
			access_check(slot_addr(regmap_pkg::slot_id_t'(i)), next_random(32));
		end
		access_check(16'h00FC, next_random(32));
		access_check(16'h0140, next_random(32));
		access_check(16'h0106, next_random(32));
		access_check(16'h8000 | 16'(next_random(15)), next_random(32));
	endtask

	task automatic test_fabric_access();
		regmap_pkg::slot_id_t id;
		id = regmap_pkg::slot_id_t'(next_random(2));
		fabric_write(id, next_random(32));
		fabric_read(id);
		fabric_write_read(id, next_random(32));
		fabric_read(id);
		fabric_write(`BURST_SIZE_ID, 32'd65 + next_random(8));
		fabric_read(`BURST_SIZE_ID);
	endtask

	task automatic test_poll_slots();
		regmap_pkg::slot_id_t id;
		regmap_pkg::data_t bus_word;
		id = regmap_pkg::slot_id_t'(`POLL_FIRST_ID + int'(next_random(1)));
		bus_word = next_random(32);
		write_check(slot_addr(id), bus_word);
		@(negedge clk);
		compare_word("fresh", 32'(fresh), 32'(model_fresh));
		fabric_read(id);
		fabric_write(id, ~bus_word);
		read_check(slot_addr(id));
		fabric_read(id);
	endtask

	task automatic test_fabric_priority();
		regmap_pkg::slot_id_t id;
		regmap_pkg::data_t fab_word;
		regmap_pkg::data_t bus_word;
		logic [1:0] resp;
		id = regmap_pkg::slot_id_t'(next_random(2));
		fab_word = next_random(32);
		bus_word = next_random(32);
		@(posedge clk);
		fab_wr_req[id] <= 1'b1;
		fab_wr_data[id] <= fab_word;
		model_fabric_write(id, fab_word);
		fork
			send_addr(slot_addr(id), 0);
			send_data(bus_word, 1);
		join
		repeat (10) begin
			@(negedge clk);
			compare_word("b_valid", 32'(b_valid), 32'd0);
		end
		read_check(slot_addr(id));
		@(posedge clk);
		fab_wr_req[id] <= 1'b0;
		collect_response(resp, int'(next_random(3)));
		compare_word("b_resp", 32'(resp), 32'(`RESP_OKAY));
		model_bus_commit(slot_addr(id), bus_word);
		read_check(slot_addr(id));
	endtask

	task automatic report_test(input int number, input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %0d (%s) passed", number, name);
		end else begin
			$display("test %0d (%s) failed with %0d errors", number, name,
				error_count - errors_before);
			failed_tests++;
		end
	endtask

	initial begin
		int errors_before;
		arst_n = 1'b0;
		aw_valid = 1'b0;
		aw_addr = '0;
		w_valid = 1'b0;
		w_data = '0;
		b_ready = 1'b0;
		ar_valid = 1'b0;
		ar_addr = '0;
		r_ready = 1'b0;
		fab_wr_req = '0;
		fab_wr_data = '0;
		fab_rd_req = '0;
		lfsr_state = LFSR_SEED;
		error_count = 0;
		failed_tests = 0;
		model_slot = '{default: '0};
		model_fresh = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		errors_before = error_count;
		test_random_access();
		report_test(1, "random bus access", errors_before);
		errors_before = error_count;
		test_clamping();
		report_test(2, "clamping", errors_before);
		errors_before = error_count;
		test_fixed_slots();
		report_test(3, "constant, unmapped and out-of-range slots", errors_before);
		errors_before = error_count;
		test_fabric_access();
		report_test(4, "fabric access", errors_before);
		errors_before = error_count;
		test_poll_slots();
		report_test(5, "poll slots and fresh flags", errors_before);
		errors_before = error_count;
		test_fabric_priority();
		report_test(6, "fabric write priority", errors_before);

		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
+incdir+verification
rtl/regmap_pkg.sv
rtl/reg_write_if.sv
rtl/reg_read_if.sv
rtl/axi_write_port.sv
rtl/axi_read_port.sv
rtl/reg_bank.sv
rtl/reg_slave_top.sv
verification/reg_slave_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= reg_slave_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Everything OK
VERILATOR_FLAGS ?= --timing --timescale 1ns/1ps

BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, so a crash or a missing line both fail
run: build
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
